/* common/graph_mem_pkg.sv */
// Graph memory definitions

package graph_mem_pkg;

	// Target array of a read command or response
	typedef enum logic [1:0] {
		ARRAY_IN_DEGREE  = 2'd0,
		ARRAY_OUT_DEGREE = 2'd1,
		ARRAY_EDGES_IDX  = 2'd2
	} array_kind_e;

	parameter int ARRAY_COUNT = 3;

	// Read sizes must be a power of two of bytes
	function automatic int unsigned cmd_size_bytes(
		input int unsigned vertices,
		input int unsigned vertex_bits
	);
		int unsigned bytes;
		int unsigned size;
		bytes = (vertices * vertex_bits + 7) / 8;
		size  = 1;
		for (int i = 0; i < 31; i++) begin
			if (size < bytes) begin
				size = size << 1;
			end
		end
		return size;
	endfunction

endpackage

/* common/vertex_job_pkg.sv */
// Vertex job definitions

package vertex_job_pkg;

	// Batch request FSM
	typedef enum logic [2:0] {
		REQ_IDLE       = 3'd0,
		REQ_INIT       = 3'd1,
		REQ_WAIT       = 3'd2,
		REQ_CALC       = 3'd3,
		REQ_IN_DEGREE  = 3'd4,
		REQ_OUT_DEGREE = 3'd5,
		REQ_EDGES_IDX  = 3'd6
	} vertex_req_state_e;

	// Width of one vertex field
	parameter int DEFAULT_VERTEX_BITS   = 32;
	// Vertices held in one cacheline
	parameter int DEFAULT_LINE_VERTICES = 4;
	parameter int DEFAULT_ADDR_BITS     = 32;
	parameter int DEFAULT_JOB_DEPTH     = 16;

endpackage

/* verilog/sync_fifo.sv */
// Synchronous FIFO
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16,
	localparam int COUNT_BITS = $clog2(DEPTH + 1)
) (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  push,
	input  logic [WIDTH-1:0]      data_in,
	input  logic                  pop,
	output logic [WIDTH-1:0]      data_out,
	output logic                  empty,
	output logic [COUNT_BITS-1:0] count
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS-1:0] wr_ptr;
	logic                do_push;
	logic                do_pop;

	function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] ptr);
		return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// Push is dropped when full, pop when empty
	assign do_push  = push && (count != COUNT_BITS'(DEPTH));
	assign do_pop   = pop && !empty;
	assign empty    = (count == '0);
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* vertex_fetch/vertex_read_requester.sv */
// Vertex array read requester
`timescale 1ns/1ps

module vertex_read_requester
	import graph_mem_pkg::*, vertex_job_pkg::*;
#(
	parameter int VERTEX_BITS   = DEFAULT_VERTEX_BITS,
	parameter int LINE_VERTICES = DEFAULT_LINE_VERTICES,
	parameter int ADDR_BITS     = DEFAULT_ADDR_BITS,
	localparam int LINE_BYTES   = VERTEX_BITS * LINE_VERTICES / 8,
	localparam int SIZE_BITS    = $clog2(LINE_BYTES) + 1,
	localparam int COUNT_BITS   = $clog2(LINE_VERTICES + 1)
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enable,
	input  logic                   start,
	input  logic [VERTEX_BITS-1:0] num_vertices,
	input  logic [ADDR_BITS-1:0]   in_degree_base,
	input  logic [ADDR_BITS-1:0]   out_degree_base,
	input  logic [ADDR_BITS-1:0]   edges_idx_base,
	input  logic                   collector_idle,
	input  logic                   job_room,
	output logic                   cmd_valid,
	output array_kind_e            cmd_array,
	output logic [ADDR_BITS-1:0]   cmd_addr,
	output logic [SIZE_BITS-1:0]   cmd_size,
	output logic [COUNT_BITS-1:0]  cmd_count,
	output logic                   busy_req
);

	vertex_req_state_e      state;
	vertex_req_state_e      next_state;
	logic [VERTEX_BITS-1:0] remaining;
	logic [ADDR_BITS-1:0]   line_offset;
	logic [ADDR_BITS-1:0]   in_degree_start;
	logic [ADDR_BITS-1:0]   out_degree_start;
	logic [ADDR_BITS-1:0]   edges_idx_start;
	logic [COUNT_BITS-1:0]  batch_count;
	logic                   batch_go;

	// Next batch only once the previous one has fully drained
	assign batch_go    = collector_idle && job_room && (remaining != '0);
	assign batch_count = (remaining >= VERTEX_BITS'(LINE_VERTICES)) ?
		COUNT_BITS'(LINE_VERTICES) : COUNT_BITS'(remaining);
	assign busy_req    = (state != REQ_IDLE);

	//////////////////////////////
	// Batch FSM
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= REQ_IDLE;
		end else if (enable) begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			REQ_IDLE: begin
				if (start) begin
					next_state = REQ_INIT;
				end
			end
			REQ_INIT:       next_state = REQ_WAIT;
			REQ_WAIT: begin
				if (batch_go) begin
					next_state = REQ_CALC;
				end else if (remaining == '0 && collector_idle) begin
					next_state = REQ_IDLE;
				end
			end
			REQ_CALC:       next_state = REQ_IN_DEGREE;
			REQ_IN_DEGREE:  next_state = REQ_OUT_DEGREE;
			REQ_OUT_DEGREE: next_state = REQ_EDGES_IDX;
			REQ_EDGES_IDX:  next_state = REQ_WAIT;
			default:        next_state = REQ_IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			remaining   <= '0;
			line_offset <= '0;
		end else if (enable) begin
			case (state)
				REQ_IDLE: begin
					if (start) begin
						remaining <= num_vertices;
					end
				end
				REQ_INIT:      line_offset <= '0;
				REQ_CALC:      remaining   <= remaining - VERTEX_BITS'(batch_count);
				// Edge index is the last read of a batch
				REQ_EDGES_IDX: line_offset <= line_offset + ADDR_BITS'(LINE_BYTES);
				default: ;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (enable && state == REQ_IDLE && start) begin
			in_degree_start  <= in_degree_base;
			out_degree_start <= out_degree_base;
			edges_idx_start  <= edges_idx_base;
		end
		if (enable && state == REQ_CALC) begin
			cmd_count <= batch_count;
			cmd_size  <= SIZE_BITS'(cmd_size_bytes(batch_count, VERTEX_BITS));
		end
	end

	//////////////////////////////
	// Command outputs
	//////////////////////////////

	always_comb begin
		cmd_valid = 1'b0;
		cmd_array = ARRAY_IN_DEGREE;
		cmd_addr  = in_degree_start + line_offset;
		case (state)
			REQ_IN_DEGREE: cmd_valid = enable;
			REQ_OUT_DEGREE: begin
				cmd_valid = enable;
				cmd_array = ARRAY_OUT_DEGREE;
				cmd_addr  = out_degree_start + line_offset;
			end
			REQ_EDGES_IDX: begin
				cmd_valid = enable;
				cmd_array = ARRAY_EDGES_IDX;
				cmd_addr  = edges_idx_start + line_offset;
			end
			default: ;
		endcase
	end

endmodule

/* vertex_fetch/cacheline_collector.sv */
// Cacheline response collector
`timescale 1ns/1ps

module cacheline_collector
	import graph_mem_pkg::*, vertex_job_pkg::*;
#(
	parameter int VERTEX_BITS   = DEFAULT_VERTEX_BITS,
	parameter int LINE_VERTICES = DEFAULT_LINE_VERTICES,
	localparam int LINE_BITS    = VERTEX_BITS * LINE_VERTICES,
	localparam int COUNT_BITS   = $clog2(LINE_VERTICES + 1)
) (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enable,
	input  logic                  cmd_valid,
	input  logic [COUNT_BITS-1:0] cmd_count,
	input  logic                  rsp_valid,
	input  array_kind_e           rsp_array,
	input  logic [LINE_BITS-1:0]  rsp_line,
	input  logic                  line_done,
	output logic                  lines_ready,
	output logic                  collector_idle,
	output logic [LINE_BITS-1:0]  in_degree_line,
	output logic [LINE_BITS-1:0]  out_degree_line,
	output logic [LINE_BITS-1:0]  edges_idx_line,
	output logic [COUNT_BITS-1:0] line_count
);

	logic [$clog2(ARRAY_COUNT+1)-1:0] outstanding;
	logic [ARRAY_COUNT-1:0]           captured;

	assign lines_ready    = (&captured) && (outstanding == '0);
	assign collector_idle = (captured == '0) && (outstanding == '0);

	// Reads in flight
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding <= '0;
		end else if (enable) begin
			case ({cmd_valid, rsp_valid})
				2'b10:   outstanding <= outstanding + 1'b1;
				2'b01:   outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
		end
	end

	// One flag per array slot
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			captured <= '0;
		end else if (enable) begin
			if (line_done) begin
				captured <= '0;
			end else if (rsp_valid) begin
				captured[rsp_array] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (enable && rsp_valid) begin
			case (rsp_array)
				ARRAY_IN_DEGREE:  in_degree_line  <= rsp_line;
				ARRAY_OUT_DEGREE: out_degree_line <= rsp_line;
				ARRAY_EDGES_IDX:  edges_idx_line  <= rsp_line;
				default: ;
			endcase
		end
		// All three commands of a batch carry the same count
		if (enable && cmd_valid) begin
			line_count <= cmd_count;
		end
	end

endmodule

/* vertex_fetch/vertex_job_assembler.sv */
// Vertex job assembler and queue
`timescale 1ns/1ps

module vertex_job_assembler
	import vertex_job_pkg::*;
#(
	parameter int VERTEX_BITS   = DEFAULT_VERTEX_BITS,
	parameter int LINE_VERTICES = DEFAULT_LINE_VERTICES,
	parameter int JOB_DEPTH     = DEFAULT_JOB_DEPTH,
	localparam int LINE_BITS    = VERTEX_BITS * LINE_VERTICES,
	localparam int COUNT_BITS   = $clog2(LINE_VERTICES + 1)
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enable,
	input  logic                   lines_ready,
	input  logic [LINE_BITS-1:0]   in_degree_line,
	input  logic [LINE_BITS-1:0]   out_degree_line,
	input  logic [LINE_BITS-1:0]   edges_idx_line,
	input  logic [COUNT_BITS-1:0]  line_count,
	input  logic                   job_pop,
	output logic                   line_done,
	output logic                   job_room,
	output logic                   job_valid,
	output logic [VERTEX_BITS-1:0] job_id,
	output logic [VERTEX_BITS-1:0] job_in_degree,
	output logic [VERTEX_BITS-1:0] job_out_degree,
	output logic [VERTEX_BITS-1:0] job_edges_idx,
	output logic [VERTEX_BITS-1:0] filtered_count,
	output logic                   pending
);

	localparam int LANE_BITS = (LINE_VERTICES > 1) ? $clog2(LINE_VERTICES) : 1;
	localparam int JOB_BITS  = 4 * VERTEX_BITS;
	localparam int FILL_BITS = $clog2(JOB_DEPTH + 1);

	logic [LANE_BITS-1:0]   lane;
	logic                   last_lane;
	logic [VERTEX_BITS-1:0] vertex_id;
	logic                   stage_valid;
	logic [VERTEX_BITS-1:0] stage_id;
	logic [VERTEX_BITS-1:0] stage_in;
	logic [VERTEX_BITS-1:0] stage_out;
	logic [VERTEX_BITS-1:0] stage_edges;
	logic                   push;
	logic                   drop;
	logic                   pop;
	logic [JOB_BITS-1:0]    job_word;
	logic                   queue_empty;
	logic [FILL_BITS-1:0]   queue_fill;

	// Byte 0 of a line sits in its top bits; fields are little-endian in memory
	function automatic logic [VERTEX_BITS-1:0] lane_field(
		input logic [LINE_BITS-1:0] line,
		input logic [LANE_BITS-1:0] idx
	);
		logic [VERTEX_BITS-1:0] raw;
		logic [VERTEX_BITS-1:0] swapped;
		raw = line[LINE_BITS - 1 - idx * VERTEX_BITS -: VERTEX_BITS];
		for (int b = 0; b < VERTEX_BITS / 8; b++) begin
			swapped[8*b +: 8] = raw[VERTEX_BITS - 8 - 8*b +: 8];
		end
		return swapped;
	endfunction

	//////////////////////////////
	// Lane walk
	//////////////////////////////

	assign last_lane = (COUNT_BITS'(lane) + COUNT_BITS'(1) == line_count);
	assign line_done = enable && lines_ready && last_lane;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			lane        <= '0;
			vertex_id   <= '0;
			stage_valid <= 1'b0;
		end else if (enable) begin
			stage_valid <= lines_ready;
			if (lines_ready) begin
				lane      <= last_lane ? '0 : lane + 1'b1;
				vertex_id <= vertex_id + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (enable && lines_ready) begin
			stage_id    <= vertex_id;
			stage_in    <= lane_field(in_degree_line, lane);
			stage_out   <= lane_field(out_degree_line, lane);
			stage_edges <= lane_field(edges_idx_line, lane);
		end
	end

	//////////////////////////////
	// Filter and queue
	//////////////////////////////

	// No outgoing edges means no work for this vertex
	assign push = enable && stage_valid && (stage_out != '0);
	assign drop = enable && stage_valid && (stage_out == '0);
	assign pop  = enable && job_pop && !queue_empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			filtered_count <= '0;
		end else if (drop) begin
			filtered_count <= filtered_count + 1'b1;
		end
	end

	sync_fifo #(
		.WIDTH(JOB_BITS),
		.DEPTH(JOB_DEPTH)
	) job_queue (
		.clock   (clock),
		.rstn    (rstn),
		.push    (push),
		.data_in ({stage_id, stage_in, stage_out, stage_edges}),
		.pop     (pop),
		.data_out(job_word),
		.empty   (queue_empty),
		.count   (queue_fill)
	);

	assign {job_id, job_in_degree, job_out_degree, job_edges_idx} = job_word;
	assign job_valid = !queue_empty;

	// Room for a whole line, counting the record still in the stage
	assign job_room = (int'(queue_fill) + int'(stage_valid)) <= (JOB_DEPTH - LINE_VERTICES);
	assign pending  = stage_valid || lines_ready;

endmodule

/* verilog/vertex_job_control.sv */
// Vertex job fetcher top
`timescale 1ns/1ps

module vertex_job_control
	import graph_mem_pkg::*, vertex_job_pkg::*;
#(
	parameter int VERTEX_BITS   = DEFAULT_VERTEX_BITS,
	parameter int LINE_VERTICES = DEFAULT_LINE_VERTICES,
	parameter int ADDR_BITS     = DEFAULT_ADDR_BITS,
	parameter int JOB_DEPTH     = DEFAULT_JOB_DEPTH,
	localparam int LINE_BITS    = VERTEX_BITS * LINE_VERTICES,
	localparam int SIZE_BITS    = $clog2(LINE_BITS / 8) + 1,
	localparam int COUNT_BITS   = $clog2(LINE_VERTICES + 1)
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enable,
	input  logic                   start,
	input  logic [VERTEX_BITS-1:0] num_vertices,
	input  logic [ADDR_BITS-1:0]   in_degree_base,
	input  logic [ADDR_BITS-1:0]   out_degree_base,
	input  logic [ADDR_BITS-1:0]   edges_idx_base,
	input  logic                   rsp_valid,
	input  array_kind_e            rsp_array,
	input  logic [LINE_BITS-1:0]   rsp_line,
	output logic                   cmd_valid,
	output array_kind_e            cmd_array,
	output logic [ADDR_BITS-1:0]   cmd_addr,
	output logic [SIZE_BITS-1:0]   cmd_size,
	output logic [COUNT_BITS-1:0]  cmd_count,
	output logic                   job_valid,
	output logic [VERTEX_BITS-1:0] job_id,
	output logic [VERTEX_BITS-1:0] job_in_degree,
	output logic [VERTEX_BITS-1:0] job_out_degree,
	output logic [VERTEX_BITS-1:0] job_edges_idx,
	input  logic                   job_pop,
	output logic [VERTEX_BITS-1:0] filtered_count,
	output logic                   busy
);

	logic                  collector_idle;
	logic                  job_room;
	logic                  lines_ready;
	logic                  line_done;
	logic [LINE_BITS-1:0]  in_degree_line;
	logic [LINE_BITS-1:0]  out_degree_line;
	logic [LINE_BITS-1:0]  edges_idx_line;
	logic [COUNT_BITS-1:0] line_count;
	logic                  busy_req;
	logic                  pending;

	vertex_read_requester #(
		.VERTEX_BITS  (VERTEX_BITS),
		.LINE_VERTICES(LINE_VERTICES),
		.ADDR_BITS    (ADDR_BITS)
	) requester (
		.clock          (clock),
		.rstn           (rstn),
		.enable         (enable),
		.start          (start),
		.num_vertices   (num_vertices),
		.in_degree_base (in_degree_base),
		.out_degree_base(out_degree_base),
		.edges_idx_base (edges_idx_base),
		.collector_idle (collector_idle),
		.job_room       (job_room),
		.cmd_valid      (cmd_valid),
		.cmd_array      (cmd_array),
		.cmd_addr       (cmd_addr),
		.cmd_size       (cmd_size),
		.cmd_count      (cmd_count),
		.busy_req       (busy_req)
	);

	cacheline_collector #(
		.VERTEX_BITS  (VERTEX_BITS),
		.LINE_VERTICES(LINE_VERTICES)
	) collector (
		.clock          (clock),
		.rstn           (rstn),
		.enable         (enable),
		.cmd_valid      (cmd_valid),
		.cmd_count      (cmd_count),
		.rsp_valid      (rsp_valid),
		.rsp_array      (rsp_array),
		.rsp_line       (rsp_line),
		.line_done      (line_done),
		.lines_ready    (lines_ready),
		.collector_idle (collector_idle),
		.in_degree_line (in_degree_line),
		.out_degree_line(out_degree_line),
		.edges_idx_line (edges_idx_line),
		.line_count     (line_count)
	);

	vertex_job_assembler #(
		.VERTEX_BITS  (VERTEX_BITS),
		.LINE_VERTICES(LINE_VERTICES),
		.JOB_DEPTH    (JOB_DEPTH)
	) assembler (
		.clock          (clock),
		.rstn           (rstn),
		.enable         (enable),
		.lines_ready    (lines_ready),
		.in_degree_line (in_degree_line),
		.out_degree_line(out_degree_line),
		.edges_idx_line (edges_idx_line),
		.line_count     (line_count),
		.job_pop        (job_pop),
		.line_done      (line_done),
		.job_room       (job_room),
		.job_valid      (job_valid),
		.job_id         (job_id),
		.job_in_degree  (job_in_degree),
		.job_out_degree (job_out_degree),
		.job_edges_idx  (job_edges_idx),
		.filtered_count (filtered_count),
		.pending        (pending)
	);

	// Requester covers fetch, assembler covers the tail of the last line
	assign busy = busy_req || pending;

endmodule

/* test/tb_vertex_job_control.sv */
// Vertex job fetcher testbench
`timescale 1ns/1ps

module tb_vertex_job_control
	import graph_mem_pkg::*, vertex_job_pkg::*;
();

	localparam int VERTEX_BITS   = DEFAULT_VERTEX_BITS;
	localparam int LINE_VERTICES = DEFAULT_LINE_VERTICES;
	localparam int LINE_BITS     = VERTEX_BITS * LINE_VERTICES;
	localparam int LINE_BYTES    = LINE_BITS / 8;
	localparam int FIELD_BYTES   = VERTEX_BITS / 8;
	localparam int MODEL_DEPTH   = 64;
	localparam logic [31:0] SEED = 32'h5599_8c9a;

	localparam int T_RESET   = 0;
	localparam int T_CMD     = 1;
	localparam int T_JOBS    = 2;
	localparam int T_FILTER  = 3;
	localparam int T_PARTIAL = 4;
	localparam int T_BACK    = 5;

	localparam int C_BUSY_HIGH = 0;
	localparam int C_BUSY_LOW  = 1;
	localparam int C_JOB_SHOWN = 2;
	localparam int C_DRAINED   = 3;

	logic                     clock = 1'b0;
	logic                     rstn = 1'b0;
	logic                     enable = 1'b0;
	logic                     start = 1'b0;
	logic [VERTEX_BITS-1:0]   num_vertices = '0;
	logic [31:0]              in_degree_base = '0;
	logic [31:0]              out_degree_base = '0;
	logic [31:0]              edges_idx_base = '0;
	logic                     rsp_valid = 1'b0;
	array_kind_e              rsp_array = ARRAY_IN_DEGREE;
	logic [LINE_BITS-1:0]     rsp_line = '0;
	logic                     job_pop = 1'b0;
	logic                     cmd_valid;
	array_kind_e              cmd_array;
	logic [31:0]              cmd_addr;
	logic [4:0]               cmd_size;
	logic [2:0]               cmd_count;
	logic                     job_valid;
	logic [VERTEX_BITS-1:0]   job_id;
	logic [VERTEX_BITS-1:0]   job_in_degree;
	logic [VERTEX_BITS-1:0]   job_out_degree;
	logic [VERTEX_BITS-1:0]   job_edges_idx;
	logic [VERTEX_BITS-1:0]   filtered_count;
	logic                     busy;
	logic [4*VERTEX_BITS-1:0] job_head;

	// Memory image and bookkeeping
	logic [31:0] model_mem [3][MODEL_DEPTH];
	logic [31:0] mem_base [3] = '{32'h0001_0000, 32'h0002_0000, 32'h0003_0000};
	string       test_names [6] = '{"reset", "commands", "job_contents", "filtering",
		"partial_line", "back_pressure"};
	int          test_errors [6] = '{0, 0, 0, 0, 0, 0};
	int          error_total = 0;
	int          expect_ids [$];
	int          expected_filtered = 0;
	int          filtered_at_start = 0;
	int          popped_run = 0;
	int          run_first = 0;
	int          run_n = 0;
	int          cmd_seen = 0;
	int          cmd_cycle = 0;
	int          last_cmd_cycle = 0;
	int          last_count = 0;
	int          last_size = 0;
	logic        pop_en = 1'b0;
	logic [31:0] mem_state;
	logic [31:0] pop_state = SEED ^ 32'h0f0f_3c3c;

	always #2 clock = ~clock;

	vertex_job_control DUT (
		.clock          (clock),
		.rstn           (rstn),
		.enable         (enable),
		.start          (start),
		.num_vertices   (num_vertices),
		.in_degree_base (in_degree_base),
		.out_degree_base(out_degree_base),
		.edges_idx_base (edges_idx_base),
		.rsp_valid      (rsp_valid),
		.rsp_array      (rsp_array),
		.rsp_line       (rsp_line),
		.cmd_valid      (cmd_valid),
		.cmd_array      (cmd_array),
		.cmd_addr       (cmd_addr),
		.cmd_size       (cmd_size),
		.cmd_count      (cmd_count),
		.job_valid      (job_valid),
		.job_id         (job_id),
		.job_in_degree  (job_in_degree),
		.job_out_degree (job_out_degree),
		.job_edges_idx  (job_edges_idx),
		.job_pop        (job_pop),
		.filtered_count (filtered_count),
		.busy           (busy)
	);

	assign job_head = {job_id, job_in_degree, job_out_degree, job_edges_idx};

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Smallest power of two of bytes covering the vertices
	function automatic int size_for(input int vertices);
		int bytes;
		int size;
		bytes = vertices * FIELD_BYTES;
		size = 1;
		while (size < bytes) begin
			size = size * 2;
		end
		return size;
	endfunction

	// Little-endian values with the lowest address byte at the top of the line
	function automatic logic [LINE_BITS-1:0] build_line(input int kind, input logic [31:0] addr);
		logic [LINE_BITS-1:0] line;
		logic [31:0]          value;
		int                   first;
		int                   idx;
		first = int'((addr - mem_base[kind]) >> 2);
		line = '0;
		for (int lane = 0; lane < LINE_VERTICES; lane++) begin
			idx = first + lane;
			value = (idx < MODEL_DEPTH) ? model_mem[kind][idx] : 32'h0;
			for (int b = 0; b < FIELD_BYTES; b++) begin
				line[LINE_BITS - 1 - 8*(FIELD_BYTES*lane + b) -: 8] = value[8*b +: 8];
			end
		end
		return line;
	endfunction

	task automatic log_mismatch(input int t, input string what, input logic [63:0] exp,
		input logic [63:0] act);
		$display("mismatch %s %s expected 0x%0h actual 0x%0h", test_names[t], what, exp, act);
		test_errors[t]++;
		error_total++;
	endtask

	task automatic note_failure(input int t, input string text);
		$display("%s: %s", test_names[t], text);
		test_errors[t]++;
		error_total++;
	endtask

	task automatic close_test(input int t);
		if (test_errors[t] == 0) begin
			$display("test %s: ok", test_names[t]);
		end else begin
			$display("test %s: %0d checks failed", test_names[t], test_errors[t]);
		end
	endtask

	//////////////////////////////
	// Memory model
	//////////////////////////////

	int          pend_kind [$];
	logic [31:0] pend_addr [$];
	int          pend_due [$];
	int          mem_cycle = 0;

	always @(posedge clock) begin : memory_model
		int pick;
		mem_cycle++;
		if (cmd_valid) begin
			mem_state = xorshift32(mem_state);
			pend_kind.push_back(int'(cmd_array));
			pend_addr.push_back(cmd_addr);
			pend_due.push_back(mem_cycle + 1 + int'(mem_state % 8));
		end
		// Random delays shuffle the array order of the answers
		pick = -1;
		foreach (pend_due[i]) begin
			if (pick < 0 && pend_due[i] <= mem_cycle) begin
				pick = i;
			end
		end
		rsp_valid <= 1'b0;
		if (pick >= 0) begin
			rsp_valid <= 1'b1;
			rsp_array <= array_kind_e'(pend_kind[pick]);
			rsp_line  <= build_line(pend_kind[pick], pend_addr[pick]);
			pend_kind.delete(pick);
			pend_addr.delete(pick);
			pend_due.delete(pick);
		end
	end

	//////////////////////////////
	// Command and job checks
	//////////////////////////////

	always @(posedge clock) begin : command_monitor
		int batch;
		int kind;
		int left;
		int exp_count;
		cmd_cycle++;
		if (cmd_valid) begin
			batch = cmd_seen / ARRAY_COUNT;
			kind = cmd_seen % ARRAY_COUNT;
			left = run_n - LINE_VERTICES * batch;
			exp_count = (left > LINE_VERTICES) ? LINE_VERTICES : left;
			if (left <= 0) begin
				note_failure(T_CMD, "read command issued after the last vertex");
			end else begin
				assert (int'(cmd_array) == kind)
					else log_mismatch(T_CMD, "cmd_array", kind, cmd_array);
				assert (cmd_addr == mem_base[kind] + 32'(4 * run_first + LINE_BYTES * batch))
					else log_mismatch(T_CMD, "cmd_addr",
						mem_base[kind] + 32'(4 * run_first + LINE_BYTES * batch), cmd_addr);
				assert (int'(cmd_count) == exp_count)
					else log_mismatch(T_CMD, "cmd_count", exp_count, cmd_count);
				assert (int'(cmd_size) == size_for(exp_count))
					else log_mismatch(T_CMD, "cmd_size", size_for(exp_count), cmd_size);
				if (kind != 0) begin
					assert (cmd_cycle == last_cmd_cycle + 1)
						else note_failure(T_CMD, "batch commands are not on consecutive cycles");
				end
			end
			last_cmd_cycle = cmd_cycle;
			last_count = int'(cmd_count);
			last_size = int'(cmd_size);
			cmd_seen++;
		end
	end

	// Consumer pops at random while allowed
	always @(posedge clock) begin : consumer
		int id;
		if (job_pop && job_valid) begin
			if (expect_ids.size() == 0) begin
				note_failure(T_JOBS, "a job was popped when none was expected");
			end else begin
				id = expect_ids.pop_front();
				assert (job_id == VERTEX_BITS'(id))
					else log_mismatch(T_JOBS, "job_id", id, job_id);
				assert (job_in_degree == model_mem[0][id])
					else log_mismatch(T_JOBS, "job_in_degree", model_mem[0][id], job_in_degree);
				assert (job_out_degree == model_mem[1][id])
					else log_mismatch(T_JOBS, "job_out_degree", model_mem[1][id], job_out_degree);
				assert (job_edges_idx == model_mem[2][id])
					else log_mismatch(T_JOBS, "job_edges_idx", model_mem[2][id], job_edges_idx);
				assert (job_out_degree != '0)
					else note_failure(T_FILTER, "a job with zero out-degree was queued");
				popped_run++;
			end
		end
		pop_state = xorshift32(pop_state);
		job_pop <= pop_en && pop_state[3];
	end

	// Head must hold while nobody pops
	head_held: assert property (@(posedge clock) disable iff (!rstn)
		(job_valid && !job_pop) |=> (job_valid && $stable(job_head)))
		else note_failure(T_BACK, "job head changed or vanished without a pop");

	out_after_in: assert property (@(posedge clock) disable iff (!rstn)
		(cmd_valid && cmd_array == ARRAY_IN_DEGREE) |=>
		(cmd_valid && cmd_array == ARRAY_OUT_DEGREE))
		else note_failure(T_CMD, "out-degree read did not follow the in-degree read");

	edges_after_out: assert property (@(posedge clock) disable iff (!rstn)
		(cmd_valid && cmd_array == ARRAY_OUT_DEGREE) |=>
		(cmd_valid && cmd_array == ARRAY_EDGES_IDX))
		else note_failure(T_CMD, "edge index read did not follow the out-degree read");

	//////////////////////////////
	// Sequencing
	//////////////////////////////

	function automatic bit cond_true(input int cond);
		case (cond)
			C_BUSY_HIGH: return busy;
			C_BUSY_LOW:  return !busy;
			C_JOB_SHOWN: return job_valid;
			default:     return expect_ids.size() == 0;
		endcase
	endfunction

	task automatic wait_until(input int cond, input int limit, input string what, output bit ok);
		ok = 1'b0;
		for (int n = 0; n < limit; n++) begin
			@(posedge clock);
			if (cond_true(cond)) begin
				ok = 1'b1;
				break;
			end
		end
		if (!ok) begin
			$display("timeout waiting for %s", what);
		end
	endtask

	task automatic run_graph(input int first, input int n, input bit stall, output bit ok);
		run_first = first;
		run_n = n;
		cmd_seen = 0;
		popped_run = 0;
		filtered_at_start = expected_filtered;
		for (int i = first; i < first + n; i++) begin
			if (model_mem[1][i] == 32'h0) begin
				expected_filtered++;
			end else begin
				expect_ids.push_back(i);
			end
		end
		pop_en <= !stall;
		@(posedge clock);
		start           <= 1'b1;
		num_vertices    <= VERTEX_BITS'(n);
		in_degree_base  <= mem_base[0] + 32'(4 * first);
		out_degree_base <= mem_base[1] + 32'(4 * first);
		edges_idx_base  <= mem_base[2] + 32'(4 * first);
		@(posedge clock);
		start <= 1'b0;
		wait_until(C_BUSY_HIGH, 10, "busy after start", ok);
		if (!ok) return;
		if (stall) begin
			wait_until(C_JOB_SHOWN, 300, "the first job", ok);
			if (!ok) return;
			// Long enough for the queue to fill and hold back further batches
			repeat (200) @(posedge clock);
			if (expect_ids.size() > 0) begin
				assert (job_valid && job_id == VERTEX_BITS'(expect_ids[0]))
					else log_mismatch(T_BACK, "stalled head id", expect_ids[0], job_id);
			end
			pop_en <= 1'b1;
		end
		wait_until(C_BUSY_LOW, 3000, "busy to fall", ok);
		if (!ok) return;
		assert (filtered_count == VERTEX_BITS'(expected_filtered))
			else log_mismatch(T_FILTER, "filtered_count", expected_filtered, filtered_count);
		assert (cmd_seen == ARRAY_COUNT * ((n + LINE_VERTICES - 1) / LINE_VERTICES))
			else log_mismatch(T_CMD, "command total",
				ARRAY_COUNT * ((n + LINE_VERTICES - 1) / LINE_VERTICES), cmd_seen);
		wait_until(C_DRAINED, 300, "all expected jobs", ok);
		if (!ok) return;
		repeat (2) @(posedge clock);
		assert (!job_valid) else note_failure(T_JOBS, "the queue holds jobs nobody expected");
	endtask

	task automatic finish_run(input bit ok);
		int failed_tests;
		failed_tests = 0;
		foreach (test_errors[t]) begin
			if (test_errors[t] != 0) begin
				failed_tests++;
			end
		end
		$display("%0d tests, %0d failed, %0d failed checks", 6, failed_tests, error_total);
		if (ok && error_total == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	initial begin
		bit          ok;
		logic [31:0] fill;
		fill = SEED;
		for (int k = 0; k < ARRAY_COUNT; k++) begin
			for (int i = 0; i < MODEL_DEPTH; i++) begin
				fill = xorshift32(fill);
				model_mem[k][i] = fill;
				// About one vertex in four has no outgoing edges
				if (k == 1 && fill[29:28] == 2'b00) begin
					model_mem[k][i] = 32'h0;
				end
			end
		end
		mem_state = xorshift32(fill);

		repeat (3) @(posedge clock);
		rstn   <= 1'b1;
		enable <= 1'b1;

		for (int c = 0; c < 8; c++) begin
			@(posedge clock);
			assert (!cmd_valid) else log_mismatch(T_RESET, "cmd_valid", 0, cmd_valid);
			assert (!job_valid) else log_mismatch(T_RESET, "job_valid", 0, job_valid);
			assert (!busy) else log_mismatch(T_RESET, "busy", 0, busy);
			assert (filtered_count == '0)
				else log_mismatch(T_RESET, "filtered_count", 0, filtered_count);
		end
		close_test(T_RESET);

		// Ten vertices end in a line of two
		run_graph(0, 10, 1'b0, ok);
		if (ok) begin
			assert (last_count == 2) else log_mismatch(T_PARTIAL, "last cmd_count", 2, last_count);
			assert (last_size == 8) else log_mismatch(T_PARTIAL, "last cmd_size", 8, last_size);
			assert (popped_run + int'(filtered_count) - filtered_at_start == 10)
				else log_mismatch(T_PARTIAL, "vertices accounted",
					10, popped_run + int'(filtered_count) - filtered_at_start);
			close_test(T_PARTIAL);
			run_graph(10, 40, 1'b1, ok);
		end
		if (ok) begin
			close_test(T_BACK);
			close_test(T_CMD);
			close_test(T_JOBS);
			close_test(T_FILTER);
		end
		finish_run(ok);
	end

endmodule

/* filelist.f */
common/graph_mem_pkg.sv
common/vertex_job_pkg.sv
verilog/sync_fifo.sv
vertex_fetch/vertex_read_requester.sv
vertex_fetch/cacheline_collector.sv
vertex_fetch/vertex_job_assembler.sv
verilog/vertex_job_control.sv
test/tb_vertex_job_control.sv

/* Bender.yml */
package:
  name: vertex_job_control

sources:
  - common/graph_mem_pkg.sv
  - common/vertex_job_pkg.sv
  - verilog/sync_fifo.sv
  - vertex_fetch/vertex_read_requester.sv
  - vertex_fetch/cacheline_collector.sv
  - vertex_fetch/vertex_job_assembler.sv
  - verilog/vertex_job_control.sv
  - target: test
    files:
      - test/tb_vertex_job_control.sv
